// File: common/uart_pkg.sv
/* Command word layout and field widths shared by the UART TX array and its testbench.
   Modules take these definitions by a wildcard import in their header. */
`default_nettype none

package uart_pkg;

    // ==============================
    // Field widths
    // ==============================
    localparam int CMD_W      = 24;
    // Channel field, caps the array at 4 channels
    localparam int CHAN_IDX_W = 2;
    // Queue level as seen by the host
    localparam int LVL_W      = 16;

    // Opcode in the top two bits of every command
    typedef enum logic [1:0] {
        OP_NOP  = 2'b00,
        OP_DATA = 2'b01,
        OP_CTRL = 2'b10,
        OP_RSVD = 2'b11
    } cmd_op_e;

    // ==============================
    // Command word views
    // ==============================
    // Data view, pushes one byte into a queue
    typedef struct packed {
        cmd_op_e                 op;
        logic [CHAN_IDX_W-1:0]   chan;
        logic [11:0]             rsvd;
        logic [7:0]              tx_byte;
    } cmd_data_s;

    // Control view, loads the prescaler and may flush the queue
    typedef struct packed {
        cmd_op_e                 op;
        logic [CHAN_IDX_W-1:0]   chan;
        logic                    clear;
        logic [2:0]              rsvd;
        logic [15:0]             prescaler;
    } cmd_ctrl_s;

    // Same 24 bits, decoded by opcode
    typedef union packed {
        cmd_data_s data;
        cmd_ctrl_s ctrl;
    } cmd_word_u;

endpackage

`default_nettype wire

// File: common/chan_if.sv
/* Per-channel bundle between the command dispatcher, one UART channel and the status
   collector. One instance per channel, connected as an array at the top level. */
`timescale 1ns/10ps
`default_nettype none

interface chan_if import uart_pkg::*; ();

    // Byte push into the channel queue
    logic              wr_stb;
    logic [7:0]        wr_byte;

    // Control command fields
    logic              cfg_stb;
    logic              cfg_clear;
    logic [15:0]       cfg_prescaler;

    // Current queue fill level
    logic [LVL_W-1:0]  level;

    // Dispatcher side
    modport ctl (output wr_stb, wr_byte, cfg_stb, cfg_clear, cfg_prescaler);

    // Channel side
    modport chan (input wr_stb, wr_byte, cfg_stb, cfg_clear, cfg_prescaler, output level);

    // Status collector only watches the level
    modport mon (input level);

endinterface

`default_nettype wire

// File: src/cmd_dispatch.sv
/* Host front end: takes 24-bit command words over a four-phase req/ack handshake
   and raises a one-cycle strobe on the addressed channel's interface. */
`timescale 1ns/10ps
`default_nettype none

module cmd_dispatch import uart_pkg::*; #(
    parameter int N_CHAN = 4
)(
    input  logic       clk,
    input  logic       rstz,
    input  logic       cmd_req_i,
    input  cmd_word_u  cmd_word_i,
    output logic       cmd_ack_o,
    chan_if.ctl        chans [N_CHAN]
);

    // Handshake state, ack is high in ST_ACK
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ACK  = 1'b1
    } hs_state_e;

    hs_state_e  state_q;
    logic       capture;
    logic       go_q;
    cmd_word_u  word_q;

    // New request seen while idle
    assign capture   = (state_q == ST_IDLE) && cmd_req_i;
    assign cmd_ack_o = (state_q == ST_ACK);

    // ==============================
    // Four-phase handshake
    // ==============================
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state_q <= ST_IDLE;
            go_q    <= 1'b0;
        end else begin
            // One-cycle pulse, lines up with ack rising
            go_q <= capture;
            case (state_q)
                ST_IDLE: if (cmd_req_i) state_q <= ST_ACK;
                ST_ACK:  if (!cmd_req_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Word held until the next request
    always_ff @(posedge clk) begin
        if (capture) begin
            word_q <= cmd_word_i;
        end
    end

    // ==============================
    // Fan out to channels
    // ==============================
    // Fields go to every channel, strobes only to the addressed one.
    // Channels at or above N_CHAN have no slot and are dropped here.
    for (genvar i = 0; i < N_CHAN; i++) begin : g_fan
        assign chans[i].wr_byte       = word_q.data.tx_byte;
        assign chans[i].cfg_clear     = word_q.ctrl.clear;
        assign chans[i].cfg_prescaler = word_q.ctrl.prescaler;
        assign chans[i].wr_stb  = go_q && (word_q.data.op == OP_DATA)
                                  && (word_q.data.chan == CHAN_IDX_W'(i));
        assign chans[i].cfg_stb = go_q && (word_q.ctrl.op == OP_CTRL)
                                  && (word_q.ctrl.chan == CHAN_IDX_W'(i));
    end

    // Ack only ever answers a pending request
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rstz)
        $rose(cmd_ack_o) |-> cmd_req_i
    );

endmodule

`default_nettype wire

// File: uart_chan/txq_fifo.sv
/* Circular byte queue with synchronous flush and an occupancy count.
   Pushes into a full queue are silently dropped. */
`timescale 1ns/10ps
`default_nettype none

module txq_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
)(
    input  logic                     clk,
    input  logic                     rstz,
    input  logic                     clear_i,
    input  logic [WIDTH-1:0]         din_i,
    input  logic                     din_vld_i,
    output logic                     din_rdy_o,
    output logic [WIDTH-1:0]         dout_o,
    output logic                     dout_vld_o,
    input  logic                     dout_rdy_i,
    output logic [$clog2(DEPTH):0]   level_o
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;

    logic [WIDTH-1:0]  mem [DEPTH];
    logic [AW-1:0]     wr_ptr_q;
    logic [AW-1:0]     rd_ptr_q;
    logic [CW-1:0]     count_q;
    logic              push;
    logic              pop;

    // Full blocks the push, which drops the byte
    assign din_rdy_o  = (count_q != CW'(DEPTH));
    assign dout_vld_o = (count_q != '0);
    assign dout_o     = mem[rd_ptr_q];
    assign level_o    = count_q;

    assign push = din_vld_i && din_rdy_o;
    assign pop  = dout_vld_o && dout_rdy_i;

    // Storage, no reset needed
    always_ff @(posedge clk) begin
        if (push && !clear_i) begin
            mem[wr_ptr_q] <= din_i;
        end
    end

    // Pointers wrap on their own, DEPTH is a power of two
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rstz)
        count_q <= CW'(DEPTH)
    );

endmodule

`default_nettype wire

// File: uart_chan/uart_tx_phy.sv
/* Serial transmitter for 8N1 frames, LSB first, each bit prescaler+1 clocks long.
   Accepts a byte only when idle; the prescaler is latched at frame start. */
`timescale 1ns/10ps
`default_nettype none

module uart_tx_phy (
    input  logic         clk,
    input  logic         rstz,
    input  logic [15:0]  prescaler_i,
    input  logic [7:0]   din_i,
    input  logic         din_vld_i,
    output logic         din_rdy_o,
    output logic         tx_o
);

    logic         busy_q;
    logic         tx_q;
    logic [15:0]  presc_q;
    logic [15:0]  baud_q;
    logic [3:0]   bit_q;
    // Remaining bits: stop then data, shifted out LSB first
    logic [8:0]   shift_q;
    logic         accept;
    logic         bit_end;

    assign din_rdy_o = !busy_q;
    assign accept    = din_vld_i && !busy_q;
    assign bit_end   = busy_q && (baud_q == presc_q);
    assign tx_o      = tx_q;

    // ==============================
    // Baud and bit counters
    // ==============================
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            busy_q <= 1'b0;
            tx_q   <= 1'b1;
            baud_q <= '0;
            bit_q  <= '0;
        end else if (accept) begin
            // Start bit goes out right away
            busy_q <= 1'b1;
            tx_q   <= 1'b0;
            baud_q <= '0;
            bit_q  <= '0;
        end else if (busy_q) begin
            if (bit_end) begin
                baud_q <= '0;
                if (bit_q == 4'd9) begin
                    // Stop bit done, line already high
                    busy_q <= 1'b0;
                end else begin
                    bit_q <= bit_q + 1'b1;
                    tx_q  <= shift_q[0];
                end
            end else begin
                baud_q <= baud_q + 1'b1;
            end
        end
    end

    // Frame payload and rate, held for the whole frame
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= {1'b1, din_i};
            presc_q <= prescaler_i;
        end else if (bit_end) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    // After an accept the line is low and no new byte is taken for 10 bit slots minimum
    a_no_accept_in_frame: assert property (
        @(posedge clk) disable iff (!rstz)
        (din_vld_i && din_rdy_o) |=> (!tx_o && !din_rdy_o) ##1 (!din_rdy_o) [*9]
    );

endmodule

`default_nettype wire

// File: uart_chan/uart_chan.sv
/* One transmit channel: prescaler register, byte queue and serial transmitter.
   Driven through its chan_if by the dispatcher; reports queue level back. */
`timescale 1ns/10ps
`default_nettype none

module uart_chan import uart_pkg::*; #(
    parameter int DEPTH             = 8,
    parameter int DEFAULT_PRESCALER = 15
)(
    input  logic  clk,
    input  logic  rstz,
    chan_if.chan  cmd,
    output logic  tx_o
);

    logic [15:0]              prescaler_q;
    logic [7:0]               q_dout;
    logic                     q_dout_vld;
    logic                     q_dout_rdy;
    logic [$clog2(DEPTH):0]   q_level;

    // Rate survives until the next control command
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            prescaler_q <= 16'(DEFAULT_PRESCALER);
        end else if (cmd.cfg_stb) begin
            prescaler_q <= cmd.cfg_prescaler;
        end
    end

    // Queue, flushed in the control command cycle
    txq_fifo #(
        .WIDTH (8),
        .DEPTH (DEPTH)
    ) u_txq (
        .clk        (clk),
        .rstz       (rstz),
        .clear_i    (cmd.cfg_stb && cmd.cfg_clear),
        .din_i      (cmd.wr_byte),
        .din_vld_i  (cmd.wr_stb),
        .din_rdy_o  (),
        .dout_o     (q_dout),
        .dout_vld_o (q_dout_vld),
        .dout_rdy_i (q_dout_rdy),
        .level_o    (q_level)
    );

    // Pops whenever the line is idle
    uart_tx_phy u_phy (
        .clk         (clk),
        .rstz        (rstz),
        .prescaler_i (prescaler_q),
        .din_i       (q_dout),
        .din_vld_i   (q_dout_vld),
        .din_rdy_o   (q_dout_rdy),
        .tx_o        (tx_o)
    );

    assign cmd.level = LVL_W'(q_level);

endmodule

`default_nettype wire

// File: src/queue_status.sv
/* Host status readback: registers the queue level of the selected channel.
   Indices with no channel behind them read as zero. */
`timescale 1ns/10ps
`default_nettype none

module queue_status import uart_pkg::*; #(
    parameter int N_CHAN = 4
)(
    input  logic                   clk,
    input  logic                   rstz,
    chan_if.mon                    chans [N_CHAN],
    input  logic [CHAN_IDX_W-1:0]  stat_chan_i,
    output logic [LVL_W-1:0]       stat_size_o
);

    // Full index space, unused slots tied to zero
    logic [LVL_W-1:0] lvl [2**CHAN_IDX_W];

    for (genvar i = 0; i < 2**CHAN_IDX_W; i++) begin : g_lvl
        if (i < N_CHAN) begin : g_live
            assign lvl[i] = chans[i].level;
        end else begin : g_none
            assign lvl[i] = '0;
        end
    end

    // One clock from select to readback
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            stat_size_o <= '0;
        end else begin
            stat_size_o <= lvl[stat_chan_i];
        end
    end

endmodule

`default_nettype wire

// File: src/uart_tx_array.sv
/* Top of the multi-channel UART TX array with plain host ports.
   Dispatcher feeds N_CHAN identical channels; status collector reads their levels. */
`timescale 1ns/10ps
`default_nettype none

module uart_tx_array import uart_pkg::*; #(
    parameter int N_CHAN = 4,
    parameter int DEPTH  = 8
)(
    input  logic                   clk,
    input  logic                   rstz,
    // Host command handshake
    input  logic                   cmd_req_i,
    input  logic [CMD_W-1:0]       cmd_word_i,
    output logic                   cmd_ack_o,
    // Queue level readback
    input  logic [CHAN_IDX_W-1:0]  stat_chan_i,
    output logic [LVL_W-1:0]       stat_size_o,
    // Serial lines
    output logic [N_CHAN-1:0]      tx_o
);

    cmd_word_u cmd_word;

    // One bundle per channel
    chan_if chan_bus [N_CHAN] ();

    assign cmd_word = cmd_word_i;

    // ==============================
    // Command front end
    // ==============================
    cmd_dispatch #(
        .N_CHAN (N_CHAN)
    ) u_dispatch (
        .clk        (clk),
        .rstz       (rstz),
        .cmd_req_i  (cmd_req_i),
        .cmd_word_i (cmd_word),
        .cmd_ack_o  (cmd_ack_o),
        .chans      (chan_bus)
    );

    // ==============================
    // Channels
    // ==============================
    for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
        uart_chan #(
            .DEPTH (DEPTH)
        ) u_chan (
            .clk  (clk),
            .rstz (rstz),
            .cmd  (chan_bus[i]),
            .tx_o (tx_o[i])
        );
    end

    // Level readback
    queue_status #(
        .N_CHAN (N_CHAN)
    ) u_status (
        .clk         (clk),
        .rstz        (rstz),
        .chans       (chan_bus),
        .stat_chan_i (stat_chan_i),
        .stat_size_o (stat_size_o)
    );

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
/* Testbench clock and reset source, 100 ns clock period.
   Holds rstz low for the first 10 clock cycles. */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rstz
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Release lines up with a rising edge
    initial begin
        rstz = 1'b0;
        repeat (10) @(posedge clk);
        rstz <= 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/tb_uart_tx_array.sv
/* Testbench for the UART TX array. Replays the records of bench/uart_stim.txt over the
   req/ack handshake, decodes every serial line and checks queue levels and bytes. */
`timescale 1ns/10ps
`default_nettype none

module tb_uart_tx_array import uart_pkg::*; ();

    // Three channels, so index 3 has nothing behind it
    localparam int N_CHAN        = 3;
    localparam int DEPTH         = 8;
    localparam int ACK_TIMEOUT   = 50;
    localparam int BYTE_TIMEOUT  = 100000;
    localparam int RESET_TIMEOUT = 100;

    logic                   clk;
    logic                   rstz;
    logic                   cmd_req;
    logic [CMD_W-1:0]       cmd_word;
    logic                   cmd_ack;
    logic [CHAN_IDX_W-1:0]  stat_chan;
    logic [LVL_W-1:0]       stat_size;
    logic [N_CHAN-1:0]      tx;

    // Bit rate per channel as last commanded
    int unsigned  presc_trk [N_CHAN];
    // Bytes recovered from each serial line
    logic [7:0]   rx_q [N_CHAN][$];
    int           checks;
    int           errors;
    bit           aborted;

    tb_clk_gen u_clk (
        .clk  (clk),
        .rstz (rstz)
    );

    uart_tx_array #(
        .N_CHAN (N_CHAN),
        .DEPTH  (DEPTH)
    ) dut (
        .clk         (clk),
        .rstz        (rstz),
        .cmd_req_i   (cmd_req),
        .cmd_word_i  (cmd_word),
        .cmd_ack_o   (cmd_ack),
        .stat_chan_i (stat_chan),
        .stat_size_o (stat_size),
        .tx_o        (tx)
    );

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    // ==============================
    // Host side
    // ==============================
    // Full four-phase cycle, ack up then back down after req drops
    task automatic handshake(input logic [CMD_W-1:0] w);
        int n;
        n = 0;
        @(posedge clk);
        cmd_word <= w;
        cmd_req  <= 1'b1;
        @(negedge clk);
        while (!cmd_ack && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!cmd_ack) begin
            $display("Handshake stalled, no ack for command %06h", w);
            aborted = 1'b1;
        end else begin
            @(posedge clk);
            cmd_req <= 1'b0;
            n = 0;
            @(negedge clk);
            // That edge still saw req high, so ack stays up
            check_eq(32'(cmd_ack), 32'd1, "ack held until req drops");
            while (cmd_ack && n < ACK_TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (cmd_ack) begin
                $display("Handshake stalled, ack stayed high after req dropped");
                aborted = 1'b1;
            end
        end
    endtask

    // Run of data commands with incrementing bytes
    task automatic push_bytes(input int ch, input int first, input int count);
        cmd_word_u w;
        for (int k = 0; k < count && !aborted; k++) begin
            w.data.op      = OP_DATA;
            w.data.chan    = CHAN_IDX_W'(ch);
            w.data.rsvd    = '0;
            w.data.tx_byte = 8'(first + k);
            handshake(w);
        end
    endtask

    task automatic configure(input int ch, input int presc, input int clear);
        cmd_word_u w;
        w.ctrl.op        = OP_CTRL;
        w.ctrl.chan      = CHAN_IDX_W'(ch);
        w.ctrl.clear     = clear[0];
        w.ctrl.rsvd      = '0;
        w.ctrl.prescaler = 16'(presc);
        // Frames that start from now on run at the new rate
        if (ch < N_CHAN) begin
            presc_trk[ch] = presc;
        end
        handshake(w);
    endtask

    // Select, then one clock to the registered readback
    task automatic read_level(input int ch, input int lvl);
        @(posedge clk);
        stat_chan <= CHAN_IDX_W'(ch);
        @(posedge clk);
        @(negedge clk);
        check_eq(32'(stat_size), 32'(lvl), $sformatf("queue level of channel %0d", ch));
    endtask

    task automatic wait_bytes(input int ch, input int first, input int count);
        int n;
        for (int k = 0; k < count && !aborted; k++) begin
            n = 0;
            while (rx_q[ch].size() == 0 && n < BYTE_TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (rx_q[ch].size() == 0) begin
                $display("Timed out waiting for byte %0d on channel %0d", k, ch);
                aborted = 1'b1;
            end else begin
                check_eq(32'(rx_q[ch].pop_front()), 32'((first + k) % 256),
                         $sformatf("byte %0d on channel %0d", k, ch));
            end
        end
    endtask

    // ==============================
    // Serial decoder
    // ==============================
    // Start, 8 data bits LSB first, stop; each bit p+1 clocks
    task automatic decode_line(input int ch);
        int unsigned  p;
        logic [8:0]   bits;
        forever begin
            @(negedge clk);
            if (!tx[ch]) begin
                // Rate latched at the start edge, sample near mid-bit
                p = presc_trk[ch];
                repeat ((p + 1) / 2) @(posedge clk);
                @(negedge clk);
                check_eq(32'(tx[ch]), 32'd0, $sformatf("start bit on channel %0d", ch));
                for (int i = 0; i < 9; i++) begin
                    repeat (p + 1) @(posedge clk);
                    @(negedge clk);
                    bits[i] = tx[ch];
                end
                check_eq(32'(bits[8]), 32'd1, $sformatf("stop bit on channel %0d", ch));
                rx_q[ch].push_back(bits[7:0]);
            end
        end
    endtask

    // ==============================
    // Record replay
    // ==============================
    initial begin : main
        int          fd;
        int          c;
        int          n;
        int          a;
        int          b;
        int          d;
        logic [7:0]  kind;
        cmd_req   = 1'b0;
        cmd_word  = '0;
        stat_chan = '0;
        checks    = 0;
        errors    = 0;
        aborted   = 1'b0;
        fd        = 0;
        // Reset rate of every channel
        for (int i = 0; i < N_CHAN; i++) begin
            presc_trk[i] = 15;
        end
        n = 0;
        while (!rstz && n < RESET_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rstz) begin
            $display("Reset was never released");
            aborted = 1'b1;
        end
        @(negedge clk);
        check_eq(32'(tx), 32'((1 << N_CHAN) - 1), "serial lines idle after reset");
        check_eq(32'(cmd_ack), 32'd0, "ack low after reset");
        for (int i = 0; i < N_CHAN; i++) begin
            fork
                automatic int ch = i;
                decode_line(ch);
            join_none
        end
        if (!aborted) begin
            fd = $fopen("bench/uart_stim.txt", "r");
        end
        if (!aborted && fd == 0) begin
            $display("Cannot open stimulus file bench/uart_stim.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": begin
                    // Rest of the line is a comment
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
                "D": begin
                    n = $fscanf(fd, "%h %h %h", a, b, d);
                    push_bytes(a, b, d);
                end
                "P": begin
                    n = $fscanf(fd, "%h %h %h", a, b, d);
                    configure(a, b, d);
                end
                "X": begin
                    n = $fscanf(fd, "%h", a);
                    handshake(CMD_W'(a));
                end
                "S": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    read_level(a, b);
                end
                "B": begin
                    n = $fscanf(fd, "%h %h %h", a, b, d);
                    wait_bytes(a, b, d);
                end
                default: begin
                    $display("Unknown record type '%c' in stimulus file", kind);
                    aborted = 1'b1;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (!aborted) begin
            // Quiet period, then nothing may be left over
            repeat (2000) @(negedge clk);
            for (int i = 0; i < N_CHAN; i++) begin
                check_eq(32'(rx_q[i].size()), 32'd0,
                         $sformatf("unexpected bytes on channel %0d", i));
            end
        end
        $display("Checks run: %0d, errors: %0d, aborted: %0d", checks, errors, aborted);
        if (errors == 0 && !aborted) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/uart_stim.txt
# Records with hex fields: D chan byte count | P chan prescaler clear | X word
#   S chan level (queue level readback) | B chan byte count (bytes expected on tx)
# Idle after reset, channel 3 does not exist
S 0 0
S 1 0
S 2 0
S 3 0
# Default rate on channel 0
D 0 41 3
B 0 41 3
# Channel 1 to 4-clock bits, channel 0 keeps its rate
P 1 3 0
D 1 a5 2
D 0 7e 1
B 1 a5 2
B 0 7e 1
# Slow channel 1 fills its queue, extra bytes dropped
P 1 fa0 0
D 1 0 3
S 1 2
D 1 3 8
S 1 8
# Flush channel 2 while its first frame is on the line
P 2 fa0 0
D 2 c1 3
S 2 2
P 2 3 1
S 2 0
S 1 8
B 2 c1 1
# Speed channel 1 up and drain it
P 1 3 0
B 1 0 9
S 1 0
# Ignored opcodes and the missing channel
X 0000aa
X c000bb
D 3 ff 1
S 0 0
S 1 0
S 2 0
S 3 0

// File: verilog.f
common/uart_pkg.sv
common/chan_if.sv
src/cmd_dispatch.sv
uart_chan/txq_fifo.sv
uart_chan/uart_tx_phy.sv
uart_chan/uart_chan.sv
src/queue_status.sv
src/uart_tx_array.sv
bench/tb_clk_gen.sv
bench/tb_uart_tx_array.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the UART TX array testbench with Verilator, judged by the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_uart_tx_array -f verilog.f \
    && ./obj_dir/Vtb_uart_tx_array | tee sim.log
grep -qsx "SIMULATION PASSED" sim.log && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }
